// ==== common/cache_pkg.sv ====
// Shared definitions for the direct-mapped write-back cache and its memory model.
// Widths, the DMA packet layout and the state and opcode enums live here.
// Design files take them with a wildcard import in the module header.

package cache_pkg;

  localparam int addr_width  = 32;
  localparam int data_width  = 32;
  localparam int block_words = 4;
  localparam int sets        = 16;
  localparam int mem_words   = 1024;

  // Address fields, low to high: byte offset, word offset, index, tag
  localparam int byte_off_width  = $clog2(data_width / 8);
  localparam int word_off_width  = $clog2(block_words);
  localparam int index_width     = $clog2(sets);
  localparam int block_off_width = byte_off_width + word_off_width;
  localparam int tag_width       = addr_width - index_width - block_off_width;

  // Memory model word address and block number widths
  localparam int mem_addr_width  = $clog2(mem_words);
  localparam int mem_block_width = mem_addr_width - word_off_width;

  typedef struct packed {
    logic                  write_not_read;
    logic [addr_width-1:0] addr;
  } dma_pkt_s;

  typedef enum logic {
    LOAD,
    STORE
  } cache_op_e;

  typedef enum logic {
    WAIT,
    BUSY
  } chan_state_e;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    EVICT,
    FILL,
    RESPOND
  } cache_state_e;

  // Prefixed so the literals do not collide with the core states
  typedef enum logic [2:0] {
    DMA_IDLE,
    DMA_SEND_WR,
    DMA_WR_DATA,
    DMA_SEND_RD,
    DMA_RD_DATA
  } dma_state_e;

endpackage

// ==== common/dma_if.sv ====
// DMA channel between the cache's DMA engine and the memory model.
// Packets and write data use valid/yumi, read data uses valid/ready.
// The cache modport drives requests, the mem modport answers them.

interface dma_if
  import cache_pkg::*;
();

  // Packet channel
  dma_pkt_s              pkt;
  logic                  pkt_v;
  logic                  pkt_yumi;

  // Read data, memory to cache
  logic [data_width-1:0] rd_data;
  logic                  rd_v;
  logic                  rd_ready;

  // Write data, cache to memory
  logic [data_width-1:0] wr_data;
  logic                  wr_v;
  logic                  wr_yumi;

  modport cache (
    output pkt, pkt_v, rd_ready, wr_data, wr_v,
    input  pkt_yumi, rd_data, rd_v, wr_yumi
  );

  modport mem (
    input  pkt, pkt_v, rd_ready, wr_data, wr_v,
    output pkt_yumi, rd_data, rd_v, wr_yumi
  );

endinterface

// ==== cache/cache_core.sv ====
// Core of the blocking direct-mapped cache: tag, valid, dirty and data arrays
// plus the request FSM. Hits respond two cycles after acceptance. Misses hand
// the block addresses to the DMA engine and wait for fill_done_i.

module cache_core
  import cache_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  logic                      req_v_i,
  input  cache_op_e                 req_op_i,
  input  logic [addr_width-1:0]     req_addr_i,
  input  logic [data_width-1:0]     req_data_i,
  output logic                      req_ready_o,
  output logic                      resp_v_o,
  output logic [data_width-1:0]     resp_data_o,

  output logic                      miss_v_o,
  output logic [addr_width-1:0]     miss_addr_o,
  output logic                      evict_o,
  output logic [addr_width-1:0]     victim_addr_o,
  input  logic                      fill_done_i,

  input  logic [word_off_width-1:0] rd_word_i,
  output logic [data_width-1:0]     rd_data_o,
  input  logic                      fill_we_i,
  input  logic [word_off_width-1:0] fill_word_i,
  input  logic [data_width-1:0]     fill_data_i
);

  cache_state_e state_r, state_n;
  logic         init_r;

  // Registered request
  cache_op_e             op_r;
  logic [addr_width-1:0] addr_r;
  logic [data_width-1:0] wdata_r;
  logic [data_width-1:0] resp_data_r;

  logic [tag_width-1:0]  tag_mem  [sets];
  logic [data_width-1:0] data_mem [sets*block_words];
  logic [sets-1:0]       valid_r;
  logic [sets-1:0]       dirty_r;

  logic [tag_width-1:0]      tag;
  logic [index_width-1:0]    idx;
  logic [word_off_width-1:0] word;
  logic                      accept;
  logic                      hit;
  logic                      in_miss;
  logic                      fill_end;
  logic                      access;

  assign tag  = addr_r[addr_width-1 -: tag_width];
  assign idx  = addr_r[block_off_width +: index_width];
  assign word = addr_r[byte_off_width +: word_off_width];

  assign accept   = req_v_i & req_ready_o;
  assign hit      = valid_r[idx] & (tag_mem[idx] == tag);
  assign in_miss  = (state_r == EVICT) | (state_r == FILL);
  assign fill_end = in_miss & fill_done_i;

  // Hits and completed fills perform the load or store in the same cycle
  assign access = ((state_r == LOOKUP) & hit) | fill_end;

  always_comb begin
    state_n = state_r;
    case (state_r)
      IDLE: begin
        if (accept) begin
          state_n = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit) begin
          state_n = RESPOND;
        end else if (valid_r[idx] & dirty_r[idx]) begin
          state_n = EVICT;
        end else begin
          state_n = FILL;
        end
      end
      EVICT, FILL: begin
        if (fill_done_i) begin
          state_n = RESPOND;
        end
      end
      RESPOND: begin
        state_n = IDLE;
      end
      default: begin
        state_n = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      init_r  <= 1'b0;
      valid_r <= '0;
      dirty_r <= '0;
    end else begin
      state_r <= state_n;
      init_r  <= 1'b1;
      if (fill_end) begin
        // Fresh line is clean unless the replayed access is a store
        valid_r[idx] <= 1'b1;
        dirty_r[idx] <= (op_r == STORE);
      end else if (access && op_r == STORE) begin
        dirty_r[idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_r    <= req_op_i;
      addr_r  <= req_addr_i;
      wdata_r <= req_data_i;
    end
    if (fill_end) begin
      tag_mem[idx] <= tag;
    end
    if (fill_we_i) begin
      data_mem[{idx, fill_word_i}] <= fill_data_i;
    end else if (access && op_r == STORE) begin
      data_mem[{idx, word}] <= wdata_r;
    end
    if (access) begin
      resp_data_r <= (op_r == LOAD) ? data_mem[{idx, word}] : '0;
    end
  end

  assign req_ready_o = (state_r == IDLE) & init_r;
  assign resp_v_o    = (state_r == RESPOND);
  assign resp_data_o = resp_data_r;

  assign miss_v_o      = in_miss;
  assign evict_o       = (state_r == EVICT);
  assign miss_addr_o   = {tag, idx, {block_off_width{1'b0}}};
  assign victim_addr_o = {tag_mem[idx], idx, {block_off_width{1'b0}}};

  // Victim words go out before the fill overwrites the same line
  assign rd_data_o = data_mem[{idx, rd_word_i}];

endmodule

// ==== cache/cache_dma.sv ====
// DMA engine of the cache. On a miss it optionally writes back the dirty
// victim block, then reads the missing block and writes it into the core.
// fill_done_o pulses the cycle after the last fill word is written.

module cache_dma
  import cache_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  logic                      miss_v_i,
  input  logic [addr_width-1:0]     miss_addr_i,
  input  logic                      evict_i,
  input  logic [addr_width-1:0]     victim_addr_i,
  output logic                      fill_done_o,

  output logic [word_off_width-1:0] rd_word_o,
  input  logic [data_width-1:0]     rd_data_i,
  output logic                      fill_we_o,
  output logic [word_off_width-1:0] fill_word_o,
  output logic [data_width-1:0]     fill_data_o,

  dma_if.cache                      dma
);

  dma_state_e                state_r, state_n;
  logic [word_off_width-1:0] cnt_r, cnt_n;
  logic                      fill_done_r, fill_done_n;
  logic                      last;

  assign last = (cnt_r == word_off_width'(block_words - 1));

  always_comb begin
    state_n      = state_r;
    cnt_n        = cnt_r;
    fill_done_n  = 1'b0;
    dma.pkt      = '0;
    dma.pkt_v    = 1'b0;
    dma.wr_v     = 1'b0;
    dma.rd_ready = 1'b0;
    fill_we_o    = 1'b0;

    case (state_r)
      DMA_IDLE: begin
        // The core still shows the miss during the fill_done pulse
        if (miss_v_i & ~fill_done_r) begin
          state_n = evict_i ? DMA_SEND_WR : DMA_SEND_RD;
        end
      end
      DMA_SEND_WR: begin
        dma.pkt_v = 1'b1;
        dma.pkt   = '{write_not_read: 1'b1, addr: victim_addr_i};
        if (dma.pkt_yumi) begin
          state_n = DMA_WR_DATA;
          cnt_n   = '0;
        end
      end
      DMA_WR_DATA: begin
        dma.wr_v = 1'b1;
        if (dma.wr_yumi) begin
          cnt_n = cnt_r + word_off_width'(1);
          if (last) begin
            state_n = DMA_SEND_RD;
          end
        end
      end
      DMA_SEND_RD: begin
        dma.pkt_v = 1'b1;
        dma.pkt   = '{write_not_read: 1'b0, addr: miss_addr_i};
        if (dma.pkt_yumi) begin
          state_n = DMA_RD_DATA;
          cnt_n   = '0;
        end
      end
      DMA_RD_DATA: begin
        dma.rd_ready = 1'b1;
        fill_we_o    = dma.rd_v;
        if (dma.rd_v) begin
          cnt_n = cnt_r + word_off_width'(1);
          if (last) begin
            state_n     = DMA_IDLE;
            fill_done_n = 1'b1;
          end
        end
      end
      default: begin
        state_n = DMA_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= DMA_IDLE;
      cnt_r       <= '0;
      fill_done_r <= 1'b0;
    end else begin
      state_r     <= state_n;
      cnt_r       <= cnt_n;
      fill_done_r <= fill_done_n;
    end
  end

  // One counter indexes both the victim stream and the fill stream
  assign rd_word_o   = cnt_r;
  assign dma.wr_data = rd_data_i;
  assign fill_word_o = cnt_r;
  assign fill_data_o = dma.rd_data;
  assign fill_done_o = fill_done_r;

endmodule

// ==== design/dma_mem_model.sv ====
// Simulation memory behind the cache's DMA channel. Holds 4 KB of words and
// serves whole blocks on independent read and write channels. A packet is
// taken only when its channel is waiting. Upper address bits alias.

module dma_mem_model
  import cache_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  dma_if.mem   dma
);

  logic [data_width-1:0] mem [mem_words];

  logic [mem_block_width-1:0] pkt_blk;
  logic                       start_rd;
  logic                       start_wr;

  chan_state_e                rd_state_r;
  logic [mem_block_width-1:0] rd_blk_r;
  logic [word_off_width-1:0]  rd_cnt_r;
  logic                       rd_take;

  chan_state_e                wr_state_r;
  logic [mem_block_width-1:0] wr_blk_r;
  logic [word_off_width-1:0]  wr_cnt_r;

  assign pkt_blk  = dma.pkt.addr[block_off_width +: mem_block_width];
  assign start_rd = dma.pkt_v & ~dma.pkt.write_not_read & (rd_state_r == WAIT);
  assign start_wr = dma.pkt_v & dma.pkt.write_not_read & (wr_state_r == WAIT);

  assign dma.pkt_yumi = start_rd | start_wr;

  // Read data stays stable while the cache holds off
  assign dma.rd_v    = (rd_state_r == BUSY);
  assign dma.rd_data = mem[{rd_blk_r, rd_cnt_r}];
  assign rd_take     = dma.rd_v & dma.rd_ready;

  // Write words are taken as soon as they show up
  assign dma.wr_yumi = (wr_state_r == BUSY) & dma.wr_v;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_state_r <= WAIT;
      rd_cnt_r   <= '0;
    end else begin
      case (rd_state_r)
        WAIT: begin
          if (start_rd) begin
            rd_state_r <= BUSY;
            rd_blk_r   <= pkt_blk;
            rd_cnt_r   <= '0;
          end
        end
        BUSY: begin
          if (rd_take) begin
            rd_cnt_r <= rd_cnt_r + word_off_width'(1);
            if (rd_cnt_r == word_off_width'(block_words - 1)) begin
              rd_state_r <= WAIT;
            end
          end
        end
        default: rd_state_r <= WAIT;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_r <= WAIT;
      wr_cnt_r   <= '0;
    end else begin
      case (wr_state_r)
        WAIT: begin
          if (start_wr) begin
            wr_state_r <= BUSY;
            wr_blk_r   <= pkt_blk;
            wr_cnt_r   <= '0;
          end
        end
        BUSY: begin
          if (dma.wr_yumi) begin
            wr_cnt_r <= wr_cnt_r + word_off_width'(1);
            if (wr_cnt_r == word_off_width'(block_words - 1)) begin
              wr_state_r <= WAIT;
            end
          end
        end
        default: wr_state_r <= WAIT;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < mem_words; i++) begin
        mem[i] <= '0;
      end
    end else if (dma.wr_yumi) begin
      mem[{wr_blk_r, wr_cnt_r}] <= dma.wr_data;
    end
  end

endmodule

// ==== design/cache_top.sv ====
// Top level of the cache system: cache core, its DMA engine and the memory
// model on one DMA channel. Requests use valid/ready, responses are single
// cycle pulses with no back-pressure.

module cache_top
  import cache_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  req_v_i,
  input  cache_op_e             req_op_i,
  input  logic [addr_width-1:0] req_addr_i,
  input  logic [data_width-1:0] req_data_i,
  output logic                  req_ready_o,

  output logic                  resp_v_o,
  output logic [data_width-1:0] resp_data_o
);

  logic                      miss_v;
  logic [addr_width-1:0]     miss_addr;
  logic                      evict;
  logic [addr_width-1:0]     victim_addr;
  logic                      fill_done;
  logic [word_off_width-1:0] rd_word;
  logic [data_width-1:0]     rd_data;
  logic                      fill_we;
  logic [word_off_width-1:0] fill_word;
  logic [data_width-1:0]     fill_data;

  dma_if dma_bus ();

  cache_core core (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_v_i       (req_v_i),
    .req_op_i      (req_op_i),
    .req_addr_i    (req_addr_i),
    .req_data_i    (req_data_i),
    .req_ready_o   (req_ready_o),
    .resp_v_o      (resp_v_o),
    .resp_data_o   (resp_data_o),
    .miss_v_o      (miss_v),
    .miss_addr_o   (miss_addr),
    .evict_o       (evict),
    .victim_addr_o (victim_addr),
    .fill_done_i   (fill_done),
    .rd_word_i     (rd_word),
    .rd_data_o     (rd_data),
    .fill_we_i     (fill_we),
    .fill_word_i   (fill_word),
    .fill_data_i   (fill_data)
  );

  cache_dma dma_engine (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .miss_v_i      (miss_v),
    .miss_addr_i   (miss_addr),
    .evict_i       (evict),
    .victim_addr_i (victim_addr),
    .fill_done_o   (fill_done),
    .rd_word_o     (rd_word),
    .rd_data_i     (rd_data),
    .fill_we_o     (fill_we),
    .fill_word_o   (fill_word),
    .fill_data_o   (fill_data),
    .dma           (dma_bus.cache)
  );

  dma_mem_model mem_model (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .dma     (dma_bus.mem)
  );

endmodule

// ==== tb/tb_clock.sv ====
// Clock and reset source for the cache testbench.
// Period of 20 time units, reset held high over the first three rising edges.

module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  localparam int half_period = 10;

  initial begin
    clk_o = 1'b0;
  end

  always #half_period clk_o = ~clk_o;

  // Released shortly after the third edge, like every other driven input
  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #2 reset_o = 1'b0;
  end

endmodule

// ==== tb/cache_assertions.sv ====
// Protocol checks on the DMA channel as seen by the memory model.
// Bound into every dma_mem_model instance.

module cache_assertions
  import cache_pkg::*;
(
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  pkt_v_i,
  input logic                  pkt_yumi_i,
  input logic                  wr_v_i,
  input logic                  wr_yumi_i,
  input logic                  rd_v_i,
  input logic                  rd_ready_i,
  input logic [data_width-1:0] rd_data_i
);

  pkt_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    pkt_yumi_i |-> pkt_v_i)
    else $error("Packet yumi raised with no valid packet");

  wr_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    wr_yumi_i |-> wr_v_i)
    else $error("Write yumi raised with no valid write word");

  // A read word that is not taken must stay offered unchanged
  rd_word_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (rd_v_i && !rd_ready_i) |=> (rd_v_i && $stable(rd_data_i)))
    else $error("Read data dropped or changed before it was taken");

endmodule

bind dma_mem_model cache_assertions dma_checks (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .pkt_v_i    (dma.pkt_v),
  .pkt_yumi_i (dma.pkt_yumi),
  .wr_v_i     (dma.wr_v),
  .wr_yumi_i  (dma.wr_yumi),
  .rd_v_i     (dma.rd_v),
  .rd_ready_i (dma.rd_ready),
  .rd_data_i  (dma.rd_data)
);

// ==== tb/cache_tb.sv ====
// Directed testbench for the cache system top level.
// A reference word array predicts every response; an LFSR drives the random test.
// Inputs change 2 time units after the rising edge, outputs are sampled at the falling edge.

module cache_tb
  import cache_pkg::*;
();

  localparam int clk_period    = 20;
  localparam int request_count = 5 + 3 + 4 + 300 + 8;
  localparam int watchdog_cycles = request_count * 200 + 10;

  logic                  clk;
  logic                  reset;
  logic                  req_v_i;
  cache_op_e             req_op_i;
  logic [addr_width-1:0] req_addr_i;
  logic [data_width-1:0] req_data_i;
  logic                  req_ready_o;
  logic                  resp_v_o;
  logic [data_width-1:0] resp_data_o;

  logic [data_width-1:0] ref_mem [mem_words];
  logic [31:0]           lfsr_state;
  int                    errors;
  int                    checks;

  tb_clock clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  cache_top UUT (
    .clk_i       (clk),
    .reset_i     (reset),
    .req_v_i     (req_v_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .req_ready_o (req_ready_o),
    .resp_v_o    (resp_v_o),
    .resp_data_o (resp_data_o)
  );

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic random_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Failure at time %0t: %s", $time, what);
  endtask

  task automatic drive_request(input cache_op_e op, input logic [addr_width-1:0] addr,
                               input logic [data_width-1:0] wdata);
    req_v_i    = 1'b1;
    req_op_i   = op;
    req_addr_i = addr;
    req_data_i = wdata;
  endtask

  // Expected response from the reference array, which a store also updates
  task automatic predict_response(input cache_op_e op, input logic [addr_width-1:0] addr,
                                  input logic [data_width-1:0] wdata,
                                  output logic [data_width-1:0] expected);
    logic [mem_addr_width-1:0] word;
    word = addr[byte_off_width +: mem_addr_width];
    if (op == STORE) begin
      ref_mem[word] = wdata;
      expected      = '0;
    end else begin
      expected = ref_mem[word];
    end
  endtask

  // Latency counts cycles from acceptance up to the response cycle
  task automatic issue_request(input cache_op_e op, input logic [addr_width-1:0] addr,
                               input logic [data_width-1:0] wdata,
                               output logic [data_width-1:0] rdata, output int latency);
    drive_request(op, addr, wdata);
    @(negedge clk);
    while (!req_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    req_v_i = 1'b0;
    latency = 1;
    @(negedge clk);
    while (!resp_v_o) begin
      @(negedge clk);
      latency++;
    end
    rdata = resp_data_o;
    @(posedge clk);
    #2;
  endtask

  task automatic access_word(input cache_op_e op, input logic [addr_width-1:0] addr,
                             input logic [data_width-1:0] wdata, output int latency);
    logic [data_width-1:0] expected;
    logic [data_width-1:0] rdata;
    predict_response(op, addr, wdata, expected);
    issue_request(op, addr, wdata, rdata, latency);
    check_value(rdata, expected, $sformatf("%s at %h", op.name(), addr));
  endtask

  task automatic test_reset_zero();
    int latency;
    access_word(LOAD, 32'h000, '0, latency);
    access_word(LOAD, 32'h010, '0, latency);
    access_word(LOAD, 32'h124, '0, latency);
    access_word(LOAD, 32'h7F8, '0, latency);
    access_word(LOAD, 32'hFFC, '0, latency);
  endtask

  task automatic test_store_load();
    int latency;
    access_word(STORE, 32'h208, 32'hA5A5_1234, latency);
    access_word(LOAD, 32'h208, '0, latency);
    access_word(LOAD, 32'h208, '0, latency);
    check_value(32'(latency), 32'd2, "hit latency of repeated load");
  endtask

  // Same index 4, different tags, so the second store evicts a dirty line
  task automatic test_dirty_evict();
    int latency;
    access_word(STORE, 32'h040, 32'h1111_2222, latency);
    access_word(STORE, 32'h140, 32'h3333_4444, latency);
    access_word(LOAD, 32'h040, '0, latency);
    access_word(LOAD, 32'h140, '0, latency);
  endtask

  task automatic test_random();
    logic [31:0] bits;
    logic [31:0] wdata;
    cache_op_e   op;
    int          latency;
    for (int i = 0; i < 300; i++) begin
      random_bits(1, bits);
      op = bits[0] ? STORE : LOAD;
      random_bits(mem_addr_width, bits);
      wdata = '0;
      if (op == STORE) begin
        random_bits(32, wdata);
      end
      access_word(op, {20'b0, bits[9:0], 2'b00}, wdata, latency);
    end
  endtask

  task automatic test_back_to_back();
    logic [addr_width-1:0] addrs [8];
    logic [data_width-1:0] wdata [8];
    cache_op_e             ops [8];
    logic [data_width-1:0] exp_q [$];
    logic [data_width-1:0] expected;
    int                    issued;
    int                    responses;
    bit                    in_flight;
    bit                    taken;
    addrs     = '{32'h080, 32'h184, 32'h080, 32'h288, 32'h184, 32'h288, 32'h38C, 32'h080};
    wdata     = '{32'hCAFE_0001, 32'hCAFE_0002, 0, 32'hCAFE_0003, 0, 0, 0, 0};
    ops       = '{STORE, STORE, LOAD, STORE, LOAD, LOAD, LOAD, LOAD};
    issued    = 0;
    responses = 0;
    in_flight = 1'b0;
    drive_request(ops[0], addrs[0], wdata[0]);
    while (responses < 8) begin
      @(negedge clk);
      if (resp_v_o) begin
        if (!in_flight) begin
          report_failure("response with no request outstanding");
        end else begin
          expected = exp_q.pop_front();
          check_value(resp_data_o, expected, $sformatf("back to back response %0d", responses));
          in_flight = 1'b0;
        end
        responses++;
      end else if (in_flight && req_ready_o) begin
        report_failure("req_ready_o high while a request was still in flight");
      end
      taken = req_v_i && req_ready_o;
      @(posedge clk);
      #2;
      if (taken) begin
        predict_response(ops[issued], addrs[issued], wdata[issued], expected);
        exp_q.push_back(expected);
        in_flight = 1'b1;
        issued++;
        if (issued < 8) begin
          drive_request(ops[issued], addrs[issued], wdata[issued]);
        end else begin
          req_v_i = 1'b0;
        end
      end
    end
    check_value(32'(issued), 32'd8, "accepted back to back requests");
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    req_v_i    = 1'b0;
    req_op_i   = LOAD;
    req_addr_i = '0;
    req_data_i = '0;
    errors     = 0;
    checks     = 0;
    lfsr_state = 32'd96426;
    for (int i = 0; i < mem_words; i++) begin
      ref_mem[i] = '0;
    end
    @(negedge reset);
    @(posedge clk);
    #2;
    test_reset_zero();
    test_store_load();
    test_dirty_evict();
    test_random();
    test_back_to_back();
    $display("Finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== list.f ====
common/cache_pkg.sv
common/dma_if.sv
cache/cache_core.sv
cache/cache_dma.sv
design/dma_mem_model.sv
design/cache_top.sv
tb/tb_clock.sv
tb/cache_assertions.sv
tb/cache_tb.sv

// ==== Makefile ====
# Verilator build and run of the cache testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module cache_tb -Mdir obj_dir -f list.f
	./obj_dir/Vcache_tb | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
